//--- design/sys_pkg.sv
package sys_pkg;

	// ==============================
	// Data types
	// ==============================

	// Host word and command byte
	typedef logic [15:0] io_word_t;
	typedef logic [7:0] cmd_code_t;

	// Audio path
	typedef logic signed [15:0] sample_t;
	// Bit 4 mutes, bits 3:0 give the right shift
	typedef logic [4:0] vol_att_t;
	typedef logic [1:0] mix_t;

	// Board LEDs
	typedef logic [7:0] led_byte_t;

	// Command decoder states
	typedef enum logic {
		WAIT_CMD,
		TAKE_DATA
	} dec_state_t;

	// ==============================
	// Constants
	// ==============================

	// Host command codes
	localparam cmd_code_t CMD_CFG = 8'h01;
	localparam cmd_code_t CMD_LED = 8'h25;
	localparam cmd_code_t CMD_VOL = 8'h26;

	// Composite sync enable in the config word
	localparam int CFG_CSYNC_BIT = 3;

	// Button debounce
	localparam int DEBOUNCE_DIV = 64;
	localparam int DEBOUNCE_LEN = 8;

	// Sync interval counters
	localparam int SYNC_CNT_W = 16;

endpackage

//--- design/host_io_port.sv
module host_io_port import sys_pkg::*; (
	input  logic     clk_sys,
	input  logic     resetd,
	input  io_word_t host_data,
	input  logic     host_clk,
	input  logic     host_uio,
	output logic     host_ack,
	output logic     io_strobe,
	output io_word_t io_din,
	output logic     io_uio
);

	io_word_t data_s1;
	io_word_t data_s2;
	logic     clk_s1;
	logic     clk_s2;
	logic     uio_s1;
	logic     uio_s2;
	logic     rack;

	// Two-stage sync of the host word
	always_ff @(posedge clk_sys) begin
		data_s1 <= host_data;
		data_s2 <= data_s1;
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_s1   <= 1'b0;
			clk_s2   <= 1'b0;
			uio_s1   <= 1'b0;
			uio_s2   <= 1'b0;
			rack     <= 1'b0;
			host_ack <= 1'b0;
		end else begin
			clk_s1   <= host_clk;
			clk_s2   <= clk_s1;
			uio_s1   <= host_uio;
			uio_s2   <= uio_s1;
			// Ack trails the synced clock by two more edges
			rack     <= clk_s2;
			host_ack <= rack;
		end
	end

	// Rising level of the synced host clock
	assign io_strobe = clk_s2 & ~rack;
	assign io_din    = data_s2;
	assign io_uio    = uio_s2;

endmodule

//--- design/cmd_decoder.sv
module cmd_decoder import sys_pkg::*; (
	input  logic      clk_sys,
	input  logic      resetd,
	input  logic      io_strobe,
	input  io_word_t  io_din,
	input  logic      io_uio,
	output logic      csync_en,
	output led_byte_t led_overtake,
	output led_byte_t led_state,
	output vol_att_t  vol_att
);

	dec_state_t state;
	cmd_code_t  cmd;

	// ==============================
	// Transfer state
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state <= WAIT_CMD;
		end else if (!io_uio) begin
			// Host dropped uio, transfer is over
			state <= WAIT_CMD;
		end else if (io_strobe && state == WAIT_CMD) begin
			state <= TAKE_DATA;
		end
	end

	// First word of a transfer carries the command
	always_ff @(posedge clk_sys) begin
		if (io_uio && io_strobe && state == WAIT_CMD) begin
			cmd <= io_din[7:0];
		end
	end

	// ==============================
	// Command registers
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			csync_en     <= 1'b0;
			led_overtake <= '0;
			vol_att      <= '0;
		end else if (io_uio && io_strobe && state == TAKE_DATA) begin
			case (cmd)
				CMD_CFG: begin
					csync_en <= io_din[CFG_CSYNC_BIT];
				end
				CMD_LED: begin
					led_overtake <= io_din[15:8];
				end
				CMD_VOL: begin
					vol_att <= io_din[4:0];
				end
				default: begin
					// Unknown codes are dropped
				end
			endcase
		end
	end

	// LED levels from the low byte of an LED command
	always_ff @(posedge clk_sys) begin
		if (io_uio && io_strobe && state == TAKE_DATA && cmd == CMD_LED) begin
			led_state <= io_din[7:0];
		end
	end

endmodule

//--- design/audio_mixer.sv
module audio_mixer import sys_pkg::*; (
	input  logic     clk_sys,
	input  logic     resetd,
	input  sample_t  audio_l,
	input  sample_t  audio_r,
	input  logic     audio_signed,
	input  mix_t     audio_mix,
	input  vol_att_t vol_att,
	output sample_t  audio_out_l,
	output sample_t  audio_out_r
);

	sample_t mix_l;
	sample_t mix_r;
	logic    mix_signed;

	// Cross-mix of one channel with the other one
	function automatic sample_t cross_mix(input sample_t own, input sample_t other,
		input mix_t mix, input logic sgn);
		sample_t res;
		case (mix)
			2'd0: res = own;
			2'd1: res = sgn ? own - (own >>> 3) + (other >>> 3)
				: own - (own >> 3) + (other >> 3);
			2'd2: res = sgn ? own - (own >>> 2) + (other >>> 2)
				: own - (own >> 2) + (other >> 2);
			default: res = sgn ? (own >>> 1) + (other >>> 1)
				: (own >> 1) + (other >> 1);
		endcase
		return res;
	endfunction

	// Stage one, mix
	always_ff @(posedge clk_sys) begin
		mix_l      <= cross_mix(audio_l, audio_r, audio_mix, audio_signed);
		mix_r      <= cross_mix(audio_r, audio_l, audio_mix, audio_signed);
		mix_signed <= audio_signed;
	end

	// Stage two, mute and volume shift
	always_ff @(posedge clk_sys) begin
		if (resetd || vol_att[4]) begin
			audio_out_l <= '0;
			audio_out_r <= '0;
		end else if (mix_signed) begin
			audio_out_l <= mix_l >>> vol_att[3:0];
			audio_out_r <= mix_r >>> vol_att[3:0];
		end else begin
			audio_out_l <= mix_l >> vol_att[3:0];
			audio_out_r <= mix_r >> vol_att[3:0];
		end
	end

endmodule

//--- design/sync_polarity.sv
module sync_polarity import sys_pkg::*; (
	input  logic clk_sys,
	input  logic resetd,
	input  logic sync_in,
	output logic sync_out
);

	logic                  s1;
	logic                  s2;
	logic                  pol;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] hi_len;
	logic [SYNC_CNT_W-1:0] lo_len;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			cnt    <= '0;
			hi_len <= '0;
			lo_len <= '0;
			pol    <= 1'b0;
		end else begin
			s1 <= sync_in;
			s2 <= s1;
			// Interval that just ended
			if (s2 && !s1)
				hi_len <= cnt;
			if (!s2 && s1)
				lo_len <= cnt;
			if (s2 != s1)
				cnt <= '0;
			else if (~&cnt)
				cnt <= cnt + 1'b1;
			// Long high means the input is active low
			pol <= hi_len > lo_len;
		end
	end

	assign sync_out = sync_in ^ pol;

endmodule

//--- design/video_sync_out.sv
module video_sync_out (
	input  logic clk_sys,
	input  logic resetd,
	input  logic core_hs,
	input  logic core_vs,
	input  logic csync_en,
	output logic vga_hs,
	output logic vga_vs
);

	logic hs_pos;
	logic vs_pos;

	// Both syncs forced to active high
	sync_polarity sync_h_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.sync_in  (core_hs),
		.sync_out (hs_pos)
	);

	sync_polarity sync_v_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.sync_in  (core_vs),
		.sync_out (vs_pos)
	);

	// Composite sync goes out on the hsync pin
	assign vga_hs = csync_en ? ~(hs_pos ^ vs_pos) : ~hs_pos;
	assign vga_vs = csync_en ? 1'b1 : ~vs_pos;

endmodule

//--- design/front_panel.sv
module front_panel import sys_pkg::*; (
	input  logic      clk_sys,
	input  logic      resetd,
	input  logic      btn_user_n,
	input  logic      btn_osd_n,
	input  logic [1:0] led_power,
	input  logic [1:0] led_disk,
	input  logic      led_user,
	input  led_byte_t led_overtake,
	input  led_byte_t led_state,
	output logic      btn_user,
	output logic      btn_osd,
	output logic      power_lit,
	output logic      disk_lit,
	output logic      user_lit,
	output led_byte_t board_led
);

	localparam int DIV_W = $clog2(DEBOUNCE_DIV);

	logic [DIV_W-1:0]        div;
	logic                    tick;
	logic [1:0]              btn_raw;
	logic [1:0]              btn_q;
	logic [DEBOUNCE_LEN-1:0] hist [2];
	logic [DEBOUNCE_LEN-1:0] hist_next [2];
	led_byte_t               led_default;

	// ==============================
	// Button debounce
	// ==============================

	assign tick    = div == DIV_W'(DEBOUNCE_DIV - 1);
	assign btn_raw = ~{btn_osd_n, btn_user_n};

	always_comb begin
		for (int i = 0; i < 2; i++)
			hist_next[i] = {hist[i][DEBOUNCE_LEN-2:0], btn_raw[i]};
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			div   <= '0;
			btn_q <= '0;
			for (int i = 0; i < 2; i++)
				hist[i] <= '0;
		end else begin
			div <= tick ? '0 : div + 1'b1;
			if (tick) begin
				for (int i = 0; i < 2; i++) begin
					hist[i] <= hist_next[i];
					// Mixed history keeps the old level
					if (&hist_next[i])
						btn_q[i] <= 1'b1;
					else if (~|hist_next[i])
						btn_q[i] <= 1'b0;
				end
			end
		end
	end

	assign btn_user = btn_q[0];
	assign btn_osd  = btn_q[1];

	// ==============================
	// LEDs
	// ==============================

	// Power LED is steady on unless the core takes it
	assign power_lit = led_power[1] ? led_power[0] : 1'b1;
	assign disk_lit  = led_disk[0];
	assign user_lit  = led_user;

	assign led_default = {3'b000, power_lit, 1'b0, disk_lit, 1'b0, user_lit};
	assign board_led   = (led_overtake & led_state) | (~led_overtake & led_default);

endmodule

//--- design/sys_top.sv
module sys_top import sys_pkg::*; (
	input  logic       clk_sys,
	input  logic       resetd,
	// Host word port
	input  io_word_t   host_data,
	input  logic       host_clk,
	input  logic       host_uio,
	output logic       host_ack,
	// Core audio
	input  sample_t    audio_l,
	input  sample_t    audio_r,
	input  logic       audio_signed,
	input  mix_t       audio_mix,
	output sample_t    audio_out_l,
	output sample_t    audio_out_r,
	// Video sync
	input  logic       core_hs,
	input  logic       core_vs,
	output logic       vga_hs,
	output logic       vga_vs,
	// Core LEDs
	input  logic [1:0] led_power,
	input  logic [1:0] led_disk,
	input  logic       led_user,
	// Buttons
	input  logic       btn_user_n,
	input  logic       btn_osd_n,
	output logic       btn_user,
	output logic       btn_osd,
	// Panel and board LEDs
	output logic       power_lit,
	output logic       disk_lit,
	output logic       user_lit,
	output led_byte_t  board_led
);

	logic      io_strobe;
	io_word_t  io_din;
	logic      io_uio;
	logic      csync_en;
	led_byte_t led_overtake;
	led_byte_t led_state;
	vol_att_t  vol_att;

	host_io_port host_io_i (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.host_data (host_data),
		.host_clk  (host_clk),
		.host_uio  (host_uio),
		.host_ack  (host_ack),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.io_uio    (io_uio)
	);

	cmd_decoder cmd_dec_i (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.io_strobe    (io_strobe),
		.io_din       (io_din),
		.io_uio       (io_uio),
		.csync_en     (csync_en),
		.led_overtake (led_overtake),
		.led_state    (led_state),
		.vol_att      (vol_att)
	);

	audio_mixer audio_i (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.audio_signed (audio_signed),
		.audio_mix    (audio_mix),
		.vol_att      (vol_att),
		.audio_out_l  (audio_out_l),
		.audio_out_r  (audio_out_r)
	);

	video_sync_out vsync_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.core_hs  (core_hs),
		.core_vs  (core_vs),
		.csync_en (csync_en),
		.vga_hs   (vga_hs),
		.vga_vs   (vga_vs)
	);

	front_panel panel_i (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.btn_user_n   (btn_user_n),
		.btn_osd_n    (btn_osd_n),
		.led_power    (led_power),
		.led_disk     (led_disk),
		.led_user     (led_user),
		.led_overtake (led_overtake),
		.led_state    (led_state),
		.btn_user     (btn_user),
		.btn_osd      (btn_osd),
		.power_lit    (power_lit),
		.disk_lit     (disk_lit),
		.user_lit     (user_lit),
		.board_led    (board_led)
	);

endmodule

//--- test/tb_sys_top.sv
module tb_sys_top import sys_pkg::*; ();

	localparam int MAX_RECS = 64;

	logic       clk_sys;
	logic       resetd;
	io_word_t   host_data;
	logic       host_clk;
	logic       host_uio;
	logic       host_ack;
	sample_t    audio_l;
	sample_t    audio_r;
	logic       audio_signed;
	mix_t       audio_mix;
	sample_t    audio_out_l;
	sample_t    audio_out_r;
	logic       core_hs;
	logic       core_vs;
	logic       vga_hs;
	logic       vga_vs;
	logic [1:0] led_power;
	logic [1:0] led_disk;
	logic       led_user;
	logic       btn_user_n;
	logic       btn_osd_n;
	logic       btn_user;
	logic       btn_osd;
	logic       power_lit;
	logic       disk_lit;
	logic       user_lit;
	led_byte_t  board_led;

	// Kind, flags, then four 16-bit fields
	logic [71:0] recs [MAX_RECS];
	int          cycles;
	int          cycle_limit;

	sys_top dut_i (.*);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("timeout, the test did not finish within %0d cycles", cycle_limit);
			$display("Finished with errors");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// ==============================
	// Compare tasks
	// ==============================

	task automatic compare_sample(input string name, input sample_t exp, input sample_t act);
		if (act !== exp) begin
			$display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
			$display("Finished with errors");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic compare_led(input string name, input led_byte_t exp, input led_byte_t act);
		if (act !== exp) begin
			$display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
			$display("Finished with errors");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
			$display("Finished with errors");
			$fatal(1, "stopped at first error");
		end
	endtask

	// ==============================
	// Stimulus tasks
	// ==============================

	// Level handshake, then a short random idle gap
	task automatic send_word(input io_word_t word);
		int unsigned gap;
		@(negedge clk_sys);
		host_data = word;
		host_clk  = 1'b1;
		while (host_ack !== 1'b1)
			@(negedge clk_sys);
		host_clk = 1'b0;
		while (host_ack !== 1'b0)
			@(negedge clk_sys);
		gap = $urandom % 4;
		repeat (gap) @(negedge clk_sys);
	endtask

	task automatic host_transfer(input logic [71:0] rec);
		@(negedge clk_sys);
		host_uio = 1'b1;
		send_word({8'h00, rec[55:48]});
		send_word(rec[47:32]);
		@(negedge clk_sys);
		host_uio = 1'b0;
		// Let the decoder see uio low through the synchronizer
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic apply_leds(input logic [71:0] rec);
		@(negedge clk_sys);
		{led_power, led_disk, led_user} = rec[52:48];
		@(negedge clk_sys);
		compare_led("board_led", rec[39:32], board_led);
		compare_bit("power_lit", rec[18], power_lit);
		compare_bit("disk_lit", rec[17], disk_lit);
		compare_bit("user_lit", rec[16], user_lit);
	endtask

	task automatic apply_sample(input logic [71:0] rec);
		@(negedge clk_sys);
		audio_signed = rec[66];
		audio_mix    = rec[65:64];
		audio_l      = rec[63:48];
		audio_r      = rec[47:32];
		// Mix stage then volume stage
		repeat (2) @(negedge clk_sys);
		compare_sample("audio_out_l", rec[31:16], audio_out_l);
		compare_sample("audio_out_r", rec[15:0], audio_out_r);
	endtask

	// Active-low pulses, checked over the third frame only
	task automatic run_sync(input logic [71:0] rec);
		logic csync;
		int   hp;
		int   hw;
		int   vp;
		int   vw;
		logic hs_act;
		logic vs_act;
		csync = rec[64];
		hp    = rec[63:48];
		hw    = rec[47:32];
		vp    = rec[31:16];
		vw    = rec[15:0];
		for (int t = 0; t < 3 * vp; t++) begin
			@(negedge clk_sys);
			if (t > 2 * vp) begin
				hs_act = ~core_hs;
				vs_act = ~core_vs;
				if (csync) begin
					compare_bit("vga_hs", ~(hs_act ^ vs_act), vga_hs);
					compare_bit("vga_vs", 1'b1, vga_vs);
				end else begin
					compare_bit("vga_hs", ~hs_act, vga_hs);
					compare_bit("vga_vs", ~vs_act, vga_vs);
				end
			end
			core_hs = (t % hp) >= hw;
			core_vs = (t % vp) >= vw;
		end
		@(negedge clk_sys);
		core_hs = 1'b1;
		core_vs = 1'b1;
	endtask

	task automatic hold_buttons(input logic [71:0] rec);
		@(negedge clk_sys);
		btn_osd_n  = rec[65];
		btn_user_n = rec[64];
		repeat (rec[63:48]) @(negedge clk_sys);
		compare_bit("btn_user", rec[32], btn_user);
		compare_bit("btn_osd", rec[33], btn_osd);
	endtask

	task automatic run_records(input int n_recs);
		for (int i = 0; i < n_recs; i++) begin
			case (recs[i][71:68])
				4'h1: host_transfer(recs[i]);
				4'h2: apply_leds(recs[i]);
				4'h3: apply_sample(recs[i]);
				4'h4: run_sync(recs[i]);
				4'h5: hold_buttons(recs[i]);
				default: begin
					$display("record %0d has an unknown kind %h", i, recs[i][71:68]);
					$display("Finished with errors");
					$fatal(1, "bad test data");
				end
			endcase
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		int n_recs;
		clk_sys      = 1'b0;
		resetd       = 1'b1;
		host_data    = '0;
		// Host clock and samples busy during reset, so only reset keeps outputs low
		host_clk     = 1'b1;
		host_uio     = 1'b0;
		audio_l      = 16'h1234;
		audio_r      = 16'h4321;
		audio_signed = 1'b0;
		audio_mix    = '0;
		core_hs      = 1'b1;
		core_vs      = 1'b1;
		led_power    = '0;
		led_disk     = '0;
		led_user     = 1'b0;
		btn_user_n   = 1'b1;
		btn_osd_n    = 1'b1;
		cycles       = 0;
		cycle_limit  = 0;
		void'($urandom(12));
		for (int i = 0; i < MAX_RECS; i++)
			recs[i] = '0;
		$readmemh("test/sys_testdata.txt", recs);

		// Cycle budget per record kind
		n_recs = 0;
		while (n_recs < MAX_RECS && recs[n_recs][71:68] != 4'h0) begin
			case (recs[n_recs][71:68])
				4'h1: cycle_limit += 2 * 40;
				4'h5: cycle_limit += DEBOUNCE_DIV * 20;
				default: cycle_limit += 2000;
			endcase
			n_recs++;
		end
		cycle_limit += 100;

		if (n_recs == 0) begin
			$display("no test records were read from test/sys_testdata.txt");
			$display("Finished with errors");
			$fatal(1, "empty test data");
		end else begin
			repeat (4) @(posedge clk_sys);
			@(negedge clk_sys);
			compare_bit("host_ack", 1'b0, host_ack);
			compare_bit("btn_user", 1'b0, btn_user);
			compare_bit("btn_osd", 1'b0, btn_osd);
			compare_sample("audio_out_l", 16'h0000, audio_out_l);
			compare_sample("audio_out_r", 16'h0000, audio_out_r);
			// Only the power LED is lit with all core LED inputs low
			compare_led("board_led", 8'h10, board_led);
			host_clk = 1'b0;
			resetd   = 1'b0;
			run_records(n_recs);
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

//--- test/sys_testdata.txt
// kind flags f0 f1 f2 f3; 1 host cmd,data  2 leds in,board,lits  3 audio l,r,exp_l,exp_r
// 4 sync hp,hw,vp,vw (flag csync)  5 buttons hold,exp (flags osd_n,user_n)  0 ends the list
2_0_0000_0010_0004_0000
2_0_0013_0005_0003_0000
2_0_001C_0010_0004_0000
2_0_000F_0015_0007_0000
// LED takeover of the upper nibble
1_0_0025_F05A_0000_0000
2_0_0013_0055_0003_0000
2_0_0000_0050_0004_0000
// Audio, no shift
1_0_0026_0000_0000_0000
3_4_1234_F000_1234_F000
3_5_0800_F800_0600_FA00
3_1_0800_F800_2600_DA00
3_6_4000_C000_2000_E000
3_2_4000_C000_6000_A000
3_7_1000_E000_F800_F800
3_3_1000_E000_7800_7800
3_0_8001_7FFF_8001_7FFF
// Shift by two, then mute
1_0_0026_0002_0000_0000
3_4_8000_0404_E000_0101
3_0_8000_0404_2000_0101
1_0_0026_0013_0000_0000
3_5_1234_5678_0000_0000
// Separate sync, then composite with an unknown command in between
4_0_0028_0004_00C8_0050
1_0_0001_0008_0000_0000
1_0_007F_0000_0000_0000
4_1_0028_0004_00C8_0050
// Button press, release, short glitch, idle
5_2_0258_0001_0000_0000
5_3_0258_0000_0000_0000
5_1_0028_0000_0000_0000
5_3_0258_0000_0000_0000
0_0_0000_0000_0000_0000

//--- verilog.f
design/sys_pkg.sv
design/host_io_port.sv
design/cmd_decoder.sv
design/audio_mixer.sv
design/sync_polarity.sv
design/video_sync_out.sv
design/front_panel.sv
design/sys_top.sv
test/tb_sys_top.sv

//--- Makefile
TOP := tb_sys_top

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

.PHONY: compile run clean
